/* project.f */
verilog/rv_pkg.sv
verilog/reg_file.sv
verilog/pipe_ctrl.sv
verilog/fetch_decode.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/rv_core.sv
tb/tb_rv_core.sv

/* tb/core_vectors.txt */
# T name, then program words in hex from address 0
# S store records: word address, byte enable, data in its lanes
T alu_chain
10000513 00500093 00708113 002081b3 40118233 00352023 001242b3 00452223
00552423 ffd00313 001323b3 00133433 00752623 00852823 00309493 40135593
01c35613 00952a23 00b52c23 00c52e23 00908013 02052023 fe002e23 0000006f
S 00000100 f 00000011
S 00000104 f 0000000c
S 00000108 f 00000009
S 0000010c f 00000001
S 00000110 f 00000000
S 00000114 f 00000028
S 00000118 f fffffffe
S 0000011c f 0000000f
S 00000120 f 00000000
T load_store
10000513 876540b7 32108093 00152023 001502a3 00151523 00350103 00252623
00354183 00352823 00251203 00452a23 00255283 00128313 00652c23 00052383
00752e23 00554403 02852023 fe002e23 0000006f
S 00000100 f 87654321
S 00000104 2 00002100
S 00000108 c 43210000
S 0000010c f ffffff87
S 00000110 f 00000087
S 00000114 f ffff8765
S 00000118 f 00008766
S 0000011c f 87654321
S 00000120 f 00000021
T branches
10000513 00500093 ffd00113 00500193 05a00a13
00308463 01452023 00208463 01452223 00209463 01452423 00309463 01452623
00114463 01452823 0020c463 01452a23 0020d463 01452c23 00115463 01452e23
0020e463 03452023 00116463 03452223 00117463 03452423 0020f463 03452623
fe002e23 0000006f
S 00000104 f 0000005a
S 0000010c f 0000005a
S 00000114 f 0000005a
S 0000011c f 0000005a
S 00000124 f 0000005a
S 0000012c f 0000005a
T jumps_upper
10000513 00c000ef 03452223 03452223 00152023 02d00293 00028367 03452223
03452223 03452223 03452223 00652223 abcde3b7 12345417 00752423 00852623
fe002e23 0000006f
S 00000100 f 00000008
S 00000104 f 0000001c
S 00000108 f abcde000
S 0000010c f 12345034

/* tb/tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam word_t DONE_ADDR = 32'hffff_fffc;   // End-of-test store, not checked
    localparam int    MEM_WORDS = 256;

    logic       clk;
    logic       rst_n;
    word_t      imem_addr;
    word_t      imem_rdata;
    logic       dmem_req;
    logic       dmem_we;
    word_t      dmem_addr;
    logic [3:0] dmem_be;
    word_t      dmem_wdata;
    word_t      dmem_rdata;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];

    // Parsed vector records
    string      test_name [$];
    int         prog_start [$];
    int         prog_len [$];
    int         exp_start [$];
    int         exp_len [$];
    word_t      prog_words [$];
    word_t      exp_addr [$];
    logic [3:0] exp_be [$];
    word_t      exp_data [$];

    int   errors = 0;
    int   checks = 0;
    int   seed = 32'hdb98;
    int   cur = 0;
    int   store_idx = 0;
    logic active = 1'b0;
    logic done = 1'b0;
    logic loaded = 1'b0;

    rv_core #(.BOOT_ADDR(32'h0)) rv_core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_req_o   (dmem_req),
        .dmem_we_o    (dmem_we),
        .dmem_addr_o  (dmem_addr),
        .dmem_be_o    (dmem_be),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Memory models
    // ------------------------------------------------------------
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];   // Combinational read

    always @(posedge clk) begin
        if (dmem_req && dmem_we) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_be[b])
                    dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    function automatic word_t lane_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic compare_store(input string name, input word_t ea, input logic [3:0] eb,
                                 input word_t ed, input word_t aa, input logic [3:0] ab,
                                 input word_t ad);
        checks++;
        if (ea !== aa || eb !== ab || ed !== ad) begin
            errors++;
            $display("CHECK FAILED %s: expected %h/%b/%h, actual %h/%b/%h",
                     name, ea, eb, ed, aa, ab, ad);
        end
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Store monitor, outputs are settled at the falling edge
    always @(negedge clk) begin
        if (active && dmem_req && dmem_we) begin
            if (dmem_addr == DONE_ADDR) begin
                done = 1'b1;
            end else if (store_idx >= exp_len[cur]) begin
                errors++;
                $display("ERROR: %s wrote an unexpected store to %h", test_name[cur], dmem_addr);
                store_idx++;
            end else begin
                compare_store(test_name[cur], exp_addr[exp_start[cur] + store_idx],
                              exp_be[exp_start[cur] + store_idx],
                              exp_data[exp_start[cur] + store_idx],
                              dmem_addr, dmem_be, dmem_wdata & lane_mask(dmem_be));
                store_idx++;
            end
        end
    end

    // ------------------------------------------------------------
    // Vector loader
    // ------------------------------------------------------------
    task automatic load_vectors();
        int         fd;
        int         code;
        string      tok;
        string      name;
        word_t      a;
        logic [3:0] b;
        word_t      d;
        word_t      w;
        fd = $fopen("tb/core_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: could not open tb/core_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %s", tok);
            if (code != 1)
                break;
            if (tok[0] == "#") begin
                code = $fgets(tok, fd);          // Rest of a comment line
            end else if (tok == "T") begin
                code = $fscanf(fd, " %s", name);
                test_name.push_back(name);
                prog_start.push_back(prog_words.size());
                prog_len.push_back(0);
                exp_start.push_back(exp_addr.size());
                exp_len.push_back(0);
            end else if (tok == "S") begin
                code = $fscanf(fd, " %h %h %h", a, b, d);
                exp_addr.push_back(a);
                exp_be.push_back(b);
                exp_data.push_back(d);
                exp_len[exp_len.size() - 1]++;
            end else begin
                code = $sscanf(tok, "%h", w);
                prog_words.push_back(w);
                prog_len[prog_len.size() - 1]++;
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------
    // One test from reset
    // ------------------------------------------------------------
    task automatic run_test(input int t);
        @(posedge clk);
        #1;
        rst_n     = 1'b0;
        active    = 1'b0;
        done      = 1'b0;
        store_idx = 0;
        cur       = t;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = $random(seed);
        end
        for (int i = 0; i < prog_len[t]; i++)
            imem[i] = prog_words[prog_start[t] + i];
        repeat (16) begin
            @(negedge clk);
            compare_bit({test_name[t], " reset req"}, 1'b0, dmem_req);
            compare_bit({test_name[t], " reset we"}, 1'b0, dmem_we);
            compare_word({test_name[t], " reset pc"}, 32'h0, imem_addr);
        end
        @(posedge clk);
        #1;
        rst_n  = 1'b1;
        active = 1'b1;
        @(negedge clk);
        compare_word({test_name[t], " boot pc"}, 32'h0, imem_addr);
        compare_bit({test_name[t], " boot req"}, 1'b0, dmem_req);
        @(negedge clk);
        compare_bit({test_name[t], " boot we"}, 1'b0, dmem_we);
        while (!done)
            @(posedge clk);
        active = 1'b0;
        if (store_idx != exp_len[t]) begin
            errors++;
            $display("ERROR: %s made %0d stores but %0d were expected",
                     test_name[t], store_idx, exp_len[t]);
        end
    endtask

    // Watchdog sized from the program lengths
    initial begin
        int limit;
        wait (loaded);
        limit = 20 * prog_words.size() + 24 * test_name.size() + 20;
        repeat (limit) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        load_vectors();
        loaded = 1'b1;
        for (int t = 0; t < test_name.size(); t++)
            run_test(t);
        $display("Errors: %0d in %0d checks over %0d tests", errors, checks, test_name.size());
        if (errors == 0 && test_name.size() > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             stall_i,
    input  wire logic             flush_i,
    input  wire rv_pkg::if_id_t   if_id_i,
    input  wire rv_pkg::fwd_sel_e fwd_rs1_i,
    input  wire rv_pkg::fwd_sel_e fwd_rs2_i,
    input  wire rv_pkg::word_t    r1_i,
    input  wire rv_pkg::word_t    r2_i,
    input  wire rv_pkg::word_t    ma_result_i,
    input  wire rv_pkg::word_t    wb_data_i,
    output rv_pkg::id_ex_t        id_ex_o,
    output rv_pkg::ex_ma_t        ex_ma_o,
    output rv_pkg::word_t         ex_result_o
);
    import rv_pkg::*;

    word_t      op1;
    word_t      op2;
    word_t      alu_b;
    word_t      alu;
    word_t      agen;
    word_t      target;
    logic [4:0] shamt;
    logic       taken;
    logic       redirect;

    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t rf_val);
        case (sel)
            EX:      return ex_result_o;
            MA:      return ma_result_i;
            WB:      return wb_data_i;
            default: return rf_val;
        endcase
    endfunction

    // ------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------
    always_comb begin
        op1 = fwd_mux(fwd_rs1_i, r1_i);
        op2 = fwd_mux(fwd_rs2_i, r2_i);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            id_ex_o <= '0;
        else if (flush_i || stall_i)
            id_ex_o <= '0;                 // Bubble
        else begin
            id_ex_o.pc     <= if_id_i.pc;
            id_ex_o.rd     <= if_id_i.rd;
            id_ex_o.rf_wr  <= if_id_i.rf_wr;
            id_ex_o.mem_rd <= if_id_i.mem_rd;
            id_ex_o.mem_wr <= if_id_i.mem_wr;
            id_ex_o.op     <= if_id_i.op;
            id_ex_o.funct3 <= if_id_i.funct3;
            id_ex_o.size   <= if_id_i.size;
            id_ex_o.imm    <= if_id_i.imm;
            id_ex_o.r1     <= op1;
            id_ex_o.r2     <= op2;
        end
    end

    // ------------------------------------------------------------
    // ALU, branch compare and targets
    // ------------------------------------------------------------
    always_comb begin
        alu_b = (id_ex_o.op == OP) ? id_ex_o.r2 : id_ex_o.imm;
        shamt = alu_b[4:0];
        case (id_ex_o.funct3)
            3'b000:  alu = (id_ex_o.op == OP && id_ex_o.imm[10]) ? id_ex_o.r1 - alu_b
                                                                  : id_ex_o.r1 + alu_b;
            3'b001:  alu = id_ex_o.r1 << shamt;
            3'b010:  alu = {31'b0, $signed(id_ex_o.r1) < $signed(alu_b)};
            3'b011:  alu = {31'b0, id_ex_o.r1 < alu_b};
            3'b100:  alu = id_ex_o.r1 ^ alu_b;
            3'b101:  alu = id_ex_o.imm[10] ? word_t'($signed(id_ex_o.r1) >>> shamt)
                                           : id_ex_o.r1 >> shamt;
            3'b110:  alu = id_ex_o.r1 | alu_b;
            default: alu = id_ex_o.r1 & alu_b;
        endcase

        agen = id_ex_o.r1 + id_ex_o.imm;   // Load/store address, JALR base
        case (id_ex_o.op)
            LUI:       ex_result_o = id_ex_o.imm;
            AUIPC:     ex_result_o = id_ex_o.pc + id_ex_o.imm;
            JAL, JALR: ex_result_o = id_ex_o.pc + INSTR_BYTES;   // Link
            LOAD, STORE: ex_result_o = agen;
            default:   ex_result_o = alu;
        endcase

        case (id_ex_o.funct3)
            3'b000:  taken = id_ex_o.r1 == id_ex_o.r2;
            3'b001:  taken = id_ex_o.r1 != id_ex_o.r2;
            3'b100:  taken = $signed(id_ex_o.r1) < $signed(id_ex_o.r2);
            3'b101:  taken = $signed(id_ex_o.r1) >= $signed(id_ex_o.r2);
            3'b110:  taken = id_ex_o.r1 < id_ex_o.r2;
            3'b111:  taken = id_ex_o.r1 >= id_ex_o.r2;
            default: taken = 1'b0;
        endcase

        target   = (id_ex_o.op == JALR) ? {agen[31:1], 1'b0} : id_ex_o.pc + id_ex_o.imm;
        redirect = (id_ex_o.op == JAL) || (id_ex_o.op == JALR) ||
                   (id_ex_o.op == BRANCH && taken);
    end

    // ------------------------------------------------------------
    // EX/MA register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ex_ma_o <= '0;
        else if (flush_i)
            ex_ma_o <= '0;
        else begin
            ex_ma_o.pc            <= id_ex_o.pc;
            ex_ma_o.rd            <= id_ex_o.rd;
            ex_ma_o.rf_wr         <= id_ex_o.rf_wr;
            ex_ma_o.mem_rd        <= id_ex_o.mem_rd;
            ex_ma_o.mem_wr        <= id_ex_o.mem_wr;
            ex_ma_o.size          <= id_ex_o.size;
            ex_ma_o.load_unsigned <= id_ex_o.funct3[2];
            ex_ma_o.result        <= ex_result_o;
            ex_ma_o.addr          <= agen;
            ex_ma_o.store_data    <= id_ex_o.r2;
            ex_ma_o.redirect      <= redirect;
            ex_ma_o.target        <= target;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_decode #(
    parameter rv_pkg::word_t BOOT_ADDR = 32'h0
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          stall_i,
    input  wire logic          flush_i,
    input  wire rv_pkg::word_t redirect_pc_i,
    output rv_pkg::word_t      imem_addr_o,
    input  wire rv_pkg::word_t imem_rdata_i,
    output rv_pkg::if_id_t     if_id_o
);
    import rv_pkg::*;

    word_t  pc;
    word_t  ins;
    if_id_t dec;

    // ------------------------------------------------------------
    // Fetch PC
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= BOOT_ADDR;
        else if (flush_i)
            pc <= redirect_pc_i;          // Taken branch or jump
        else if (!stall_i)
            pc <= pc + INSTR_BYTES;
    end

    assign imem_addr_o = pc;
    assign ins         = imem_rdata_i;

    // ------------------------------------------------------------
    // Decoder
    // ------------------------------------------------------------
    always_comb begin
        dec        = '0;
        dec.instr  = ins;
        dec.pc     = pc;
        dec.op     = mopcode_e'(ins[6:2]);
        dec.funct3 = ins[14:12];
        dec.size   = mem_size_e'(ins[13:12]);
        dec.imm    = {{20{ins[31]}}, ins[31:20]};   // I-type unless overridden
        case (mopcode_e'(ins[6:2]))
            LOAD: begin
                dec.rs1    = ins[19:15];
                dec.rd     = ins[11:7];
                dec.rf_wr  = 1'b1;
                dec.mem_rd = 1'b1;
            end
            OP_IMM, JALR: begin
                dec.rs1   = ins[19:15];
                dec.rd    = ins[11:7];
                dec.rf_wr = 1'b1;
            end
            OP: begin
                dec.rs1   = ins[19:15];
                dec.rs2   = ins[24:20];
                dec.rd    = ins[11:7];
                dec.rf_wr = 1'b1;                   // funct7[5] lands in imm[10]
            end
            AUIPC, LUI: begin
                dec.rd    = ins[11:7];
                dec.rf_wr = 1'b1;
                dec.imm   = {ins[31:12], 12'b0};
            end
            STORE: begin
                dec.rs1    = ins[19:15];
                dec.rs2    = ins[24:20];
                dec.mem_wr = 1'b1;
                dec.imm    = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            end
            BRANCH: begin
                dec.rs1 = ins[19:15];
                dec.rs2 = ins[24:20];
                dec.imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            JAL: begin
                dec.rd    = ins[11:7];
                dec.rf_wr = 1'b1;
                dec.imm   = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: dec = '0;                      // Unsupported group, bubble
        endcase
        if (ins[1:0] != 2'b11)
            dec = '0;
    end

    // ------------------------------------------------------------
    // IF/ID register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            if_id_o <= '0;
        else if (flush_i)
            if_id_o <= '0;
        else if (!stall_i)
            if_id_o <= dec;
    end

    // Redirect targets come from execute
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* verilog/pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire rv_pkg::if_id_t if_id_i,
    input  wire rv_pkg::id_ex_t id_ex_i,
    input  wire rv_pkg::ex_ma_t ex_ma_i,
    input  wire rv_pkg::ma_wb_t ma_wb_i,
    output logic                stall_o,
    output logic                flush_o,
    output rv_pkg::fwd_sel_e    fwd_rs1_o,
    output rv_pkg::fwd_sel_e    fwd_rs2_o
);
    import rv_pkg::*;

    logic load_hazard;

    // Nearest producer wins
    // Loads are picked up from WB only
    function automatic fwd_sel_e fwd_pick(input reg_addr_t rs);
        if (rs == '0)
            return REG;
        if (id_ex_i.rf_wr && !id_ex_i.mem_rd && id_ex_i.rd == rs)
            return EX;
        if (ex_ma_i.rf_wr && !ex_ma_i.mem_rd && ex_ma_i.rd == rs)
            return MA;
        if (ma_wb_i.rf_wr && ma_wb_i.rd == rs)
            return WB;
        return REG;
    endfunction

    // Load data not ready yet for this source
    function automatic logic load_hit(input reg_addr_t rs);
        return (rs != '0) &&
               ((id_ex_i.mem_rd && id_ex_i.rf_wr && id_ex_i.rd == rs) ||
                (ex_ma_i.mem_rd && ex_ma_i.rf_wr && ex_ma_i.rd == rs));
    endfunction

    always_comb begin
        fwd_rs1_o   = fwd_pick(if_id_i.rs1);
        fwd_rs2_o   = fwd_pick(if_id_i.rs2);
        load_hazard = load_hit(if_id_i.rs1) || load_hit(if_id_i.rs2);
        flush_o     = ex_ma_i.redirect;
        stall_o     = load_hazard && !flush_o;   // Redirect wins
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // The forwarded producer is no load once it moves down a stage
    a_no_load_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        (fwd_rs1_o == EX || fwd_rs2_o == EX) |=> !ex_ma_i.mem_rd);

    a_no_load_fwd_ma: assert property (@(posedge clk) disable iff (!rst_n)
        (fwd_rs1_o == MA || fwd_rs2_o == MA) |=> !ma_wb_i.is_load);

    // A load drains to WB within two bubbles
    a_stall_len: assert property (@(posedge clk) disable iff (!rst_n)
        stall_o [*2] |=> !stall_o);

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire rv_pkg::reg_addr_t rs1_i,
    input  wire rv_pkg::reg_addr_t rs2_i,
    input  wire rv_pkg::reg_addr_t rd_i,
    input  wire logic             wr_i,
    input  wire rv_pkg::word_t    wrdata_i,
    output rv_pkg::word_t         r1_o,
    output rv_pkg::word_t         r2_o
);
    import rv_pkg::*;

    word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_i && rd_i != '0) begin
            regs[rd_i] <= wrdata_i;
        end
    end

    // Same-cycle write is covered by WB forwarding
    assign r1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign r2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter rv_pkg::word_t BOOT_ADDR = 32'h0
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    output rv_pkg::word_t      imem_addr_o,
    input  wire rv_pkg::word_t imem_rdata_i,
    output logic               dmem_req_o,
    output logic               dmem_we_o,
    output rv_pkg::word_t      dmem_addr_o,
    output logic [3:0]         dmem_be_o,
    output rv_pkg::word_t      dmem_wdata_o,
    input  wire rv_pkg::word_t dmem_rdata_i
);
    import rv_pkg::*;

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_ma_t   ex_ma;
    ma_wb_t   ma_wb;
    logic     stall;
    logic     flush;
    fwd_sel_e fwd_rs1;
    fwd_sel_e fwd_rs2;
    word_t    rf_r1;
    word_t    rf_r2;
    word_t    wb_data;

    pipe_ctrl pipe_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .if_id_i   (if_id),
        .id_ex_i   (id_ex),
        .ex_ma_i   (ex_ma),
        .ma_wb_i   (ma_wb),
        .stall_o   (stall),
        .flush_o   (flush),
        .fwd_rs1_o (fwd_rs1),
        .fwd_rs2_o (fwd_rs2)
    );

    fetch_decode #(.BOOT_ADDR(BOOT_ADDR)) fetch_decode_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_i       (stall),
        .flush_i       (flush),
        .redirect_pc_i (ex_ma.target),
        .imem_addr_o   (imem_addr_o),
        .imem_rdata_i  (imem_rdata_i),
        .if_id_o       (if_id)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_i    (if_id.rs1),
        .rs2_i    (if_id.rs2),
        .rd_i     (ma_wb.rd),
        .wr_i     (ma_wb.rf_wr),
        .wrdata_i (wb_data),
        .r1_o     (rf_r1),
        .r2_o     (rf_r2)
    );

    execute_stage execute_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall_i     (stall),
        .flush_i     (flush),
        .if_id_i     (if_id),
        .fwd_rs1_i   (fwd_rs1),
        .fwd_rs2_i   (fwd_rs2),
        .r1_i        (rf_r1),
        .r2_i        (rf_r2),
        .ma_result_i (ex_ma.result),
        .wb_data_i   (wb_data),
        .id_ex_o     (id_ex),
        .ex_ma_o     (ex_ma),
        .ex_result_o ()
    );

    writeback_stage writeback_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_ma_i      (ex_ma),
        .dmem_req_o   (dmem_req_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_be_o    (dmem_be_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_rdata_i (dmem_rdata_i),
        .ma_wb_o      (ma_wb),
        .wb_data_o    (wb_data)
    );

endmodule

`default_nettype wire

/* verilog/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes, instr[6:2]
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        OP_IMM = 5'b00100,
        AUIPC  = 5'b00101,
        STORE  = 5'b01000,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        BRANCH = 5'b11000,
        JALR   = 5'b11001,
        JAL    = 5'b11011
    } mopcode_e;

    typedef enum logic [1:0] {BYTE = 2'd0, HALF = 2'd1, WORD = 2'd2} mem_size_e;

    typedef enum logic [1:0] {REG, EX, MA, WB} fwd_sel_e;

    localparam int unsigned INSTR_BYTES = 4;

    // ------------------------------------------------------------
    // Stage registers
    // ------------------------------------------------------------
    typedef struct packed {
        word_t      instr;
        word_t      pc;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic       rf_wr;
        logic       mem_rd;
        logic       mem_wr;
        mopcode_e   op;
        logic [2:0] funct3;
        mem_size_e  size;
        word_t      imm;      // Sign-extended, format picked by opcode
    } if_id_t;

    typedef struct packed {
        word_t      pc;
        reg_addr_t  rd;
        logic       rf_wr;
        logic       mem_rd;
        logic       mem_wr;
        mopcode_e   op;
        logic [2:0] funct3;
        mem_size_e  size;
        word_t      imm;
        word_t      r1;       // Operands after forwarding
        word_t      r2;
    } id_ex_t;

    typedef struct packed {
        word_t      pc;
        reg_addr_t  rd;
        logic       rf_wr;
        logic       mem_rd;
        logic       mem_wr;
        mem_size_e  size;
        logic       load_unsigned;
        word_t      result;
        word_t      addr;
        word_t      store_data;
        logic       redirect;
        word_t      target;
    } ex_ma_t;

    typedef struct packed {
        reg_addr_t  rd;
        logic       rf_wr;
        logic       is_load;
        mem_size_e  size;
        logic       load_unsigned;
        word_t      result;   // Holds the address for loads
        word_t      rdata;
    } ma_wb_t;

endpackage

`default_nettype wire

/* verilog/writeback_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire rv_pkg::ex_ma_t ex_ma_i,
    output logic                dmem_req_o,
    output logic                dmem_we_o,
    output rv_pkg::word_t       dmem_addr_o,
    output logic [3:0]          dmem_be_o,
    output rv_pkg::word_t       dmem_wdata_o,
    input  wire rv_pkg::word_t  dmem_rdata_i,
    output rv_pkg::ma_wb_t      ma_wb_o,
    output rv_pkg::word_t       wb_data_o
);
    import rv_pkg::*;

    logic [1:0] ofs;
    logic [3:0] lanes;
    word_t      lane_data;
    word_t      load_data;

    // ------------------------------------------------------------
    // Data port
    // ------------------------------------------------------------
    always_comb begin
        ofs = ex_ma_i.addr[1:0];
        case (ex_ma_i.size)
            BYTE:    lanes = 4'b0001 << ofs;
            HALF:    lanes = 4'b0011 << ofs;
            default: lanes = 4'b1111;
        endcase
        dmem_req_o   = ex_ma_i.mem_rd || ex_ma_i.mem_wr;
        dmem_we_o    = ex_ma_i.mem_wr;
        dmem_addr_o  = {ex_ma_i.addr[31:2], 2'b00};
        dmem_be_o    = dmem_req_o ? lanes : 4'b0000;
        dmem_wdata_o = ex_ma_i.store_data << {ofs, 3'b000};   // Into byte lanes
    end

    // ------------------------------------------------------------
    // MA/WB register
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ma_wb_o <= '0;
        else begin
            ma_wb_o.rd            <= ex_ma_i.rd;
            ma_wb_o.rf_wr         <= ex_ma_i.rf_wr;
            ma_wb_o.is_load       <= ex_ma_i.mem_rd;
            ma_wb_o.size          <= ex_ma_i.size;
            ma_wb_o.load_unsigned <= ex_ma_i.load_unsigned;
            ma_wb_o.result        <= ex_ma_i.result;
            ma_wb_o.rdata         <= dmem_rdata_i;
        end
    end

    // Load lane select, result carries the byte address for loads
    always_comb begin
        lane_data = ma_wb_o.rdata >> {ma_wb_o.result[1:0], 3'b000};
        case (ma_wb_o.size)
            BYTE:    load_data = {{24{!ma_wb_o.load_unsigned && lane_data[7]}},
                                  lane_data[7:0]};
            HALF:    load_data = {{16{!ma_wb_o.load_unsigned && lane_data[15]}},
                                  lane_data[15:0]};
            default: load_data = lane_data;
        endcase
        wb_data_o = ma_wb_o.is_load ? load_data : ma_wb_o.result;
    end

    a_natural_align: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req_o |-> (ex_ma_i.size == BYTE) ||
                       (ex_ma_i.size == HALF && !ex_ma_i.addr[0]) ||
                       (ex_ma_i.addr[1:0] == 2'b00));

endmodule

`default_nettype wire
